//--- source/l2_bus_pkg.sv
package l2_bus_pkg;

	// Line geometry, one line is sixteen bytes
	localparam int LINE_WIDTH = 128;
	localparam int LINE_BYTES = LINE_WIDTH / 8;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);

	// Line addresses split into a set index in the low bits and a tag above it
	localparam int ADDR_BITS = 26;
	localparam int SET_BITS = 6;
	localparam int TAG_BITS = ADDR_BITS - SET_BITS;
	localparam int ID_BITS = 4;
	localparam int OP_BITS = 3;

	// Both request queues share one depth
	localparam int QUEUE_DEPTH = 8;

	// Pipeline stages ahead of this block; the queues must keep this many slots free
	localparam int REQ_LATENCY = 4;

	typedef logic [ADDR_BITS - 1:0] line_addr_t;
	typedef logic [TAG_BITS - 1:0] l2_tag_t;
	typedef logic [LINE_WIDTH - 1:0] line_t;
	typedef logic [LINE_BYTES - 1:0] byte_mask_t;
	typedef logic [ID_BITS - 1:0] req_id_t;

	typedef enum logic [OP_BITS - 1:0] {
		OP_LOAD = 3'd0,
		OP_STORE = 3'd1,
		OP_FLUSH = 3'd2,
		OP_LOAD_SYNC = 3'd3,
		OP_STORE_SYNC = 3'd4,
		OP_INVALIDATE = 3'd5
	} l2_op_e;

	// Writeback entry is {address, line}
	localparam int WB_ENTRY_WIDTH = ADDR_BITS + LINE_WIDTH;
	typedef logic [WB_ENTRY_WIDTH - 1:0] wb_entry_t;

	// Load entry is {duplicate, id, op, address, mask}
	localparam int LD_ENTRY_WIDTH = 1 + ID_BITS + OP_BITS + ADDR_BITS + LINE_BYTES;
	typedef logic [LD_ENTRY_WIDTH - 1:0] ld_entry_t;

	typedef enum logic [2:0] {
		IDLE,
		WRITE_ADDR,
		WRITE_DATA,
		READ_ADDR,
		READ_DATA,
		READ_DONE
	} bus_state_e;

endpackage

//--- source/l2_queue_if.sv
interface l2_queue_if #(
	parameter int ENTRY_WIDTH = 1
);

	// Enqueue side, driven by the classifier
	logic enqueue;
	logic [ENTRY_WIDTH - 1:0] enq_entry;
	logic almost_full;

	// Dequeue side, driven by the bus engine
	logic empty;
	logic dequeue;
	logic [ENTRY_WIDTH - 1:0] head;

	modport producer (
		output enqueue,
		output enq_entry,
		input almost_full
	);

	modport fifo (
		input enqueue,
		input enq_entry,
		input dequeue,
		output almost_full,
		output empty,
		output head
	);

	modport consumer (
		input empty,
		input head,
		output dequeue
	);

endinterface

//--- source/l2_miss_classifier.sv
module l2_miss_classifier #(
	parameter int PENDING_ENTRIES = 8
) (
	input logic clk,
	input logic reset,
	input logic rd_valid_i,
	input l2_bus_pkg::l2_op_e rd_op_i,
	input l2_bus_pkg::req_id_t rd_id_i,
	input l2_bus_pkg::line_addr_t rd_addr_i,
	input l2_bus_pkg::byte_mask_t rd_mask_i,
	input logic rd_is_fill_i,
	input logic rd_hit_i,
	input logic rd_dirty_i,
	input l2_bus_pkg::l2_tag_t rd_old_tag_i,
	input l2_bus_pkg::line_t rd_line_i,
	l2_queue_if.producer wb_q,
	l2_queue_if.producer ld_q,
	output logic input_wait_o
);
	import l2_bus_pkg::*;

	localparam int SLOT_W = (PENDING_ENTRIES > 1) ? $clog2(PENDING_ENTRIES) : 1;
	localparam int WAIT_CYCLES = REQ_LATENCY + 1;

	// Table of line addresses whose read is still outstanding
	logic [PENDING_ENTRIES - 1:0] pend_valid;
	line_addr_t pend_addr [PENDING_ENTRIES];
	logic [PENDING_ENTRIES - 1:0] match;
	logic [SLOT_W - 1:0] alloc_idx;
	logic duplicate;
	logic alloc;
	logic fill_free;
	line_addr_t wb_addr;

	// The victim lives in the same set under its old tag
	assign wb_addr = {rd_old_tag_i, rd_addr_i[SET_BITS - 1:0]};

	// Dirty lines leave the cache on a fill or on an explicit flush
	assign wb_q.enqueue = rd_valid_i && rd_dirty_i && (rd_is_fill_i || rd_op_i == OP_FLUSH);
	assign wb_q.enq_entry = {wb_addr, rd_line_i};

	// Only misses of the load and store families need a line read
	assign ld_q.enqueue = rd_valid_i && !rd_hit_i && !rd_is_fill_i
		&& (rd_op_i inside {OP_LOAD, OP_STORE, OP_LOAD_SYNC, OP_STORE_SYNC});
	assign ld_q.enq_entry = {duplicate, rd_id_i, rd_op_i, rd_addr_i, rd_mask_i};

	// Compare against every live entry and pick the lowest free slot
	always_comb
	begin
		alloc_idx = '0;
		for (int i = PENDING_ENTRIES - 1; i >= 0; i--)
		begin
			match[i] = pend_valid[i] && pend_addr[i] == rd_addr_i;
			if (!pend_valid[i])
				alloc_idx = SLOT_W'(i);
		end
	end

	assign duplicate = |match;
	assign alloc = ld_q.enqueue && !duplicate;
	assign fill_free = rd_valid_i && rd_is_fill_i;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			pend_valid <= '0;
		else if (fill_free)
			pend_valid <= pend_valid & ~match;
		else if (alloc)
			pend_valid[alloc_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
			pend_addr[alloc_idx] <= rd_addr_i;
	end

	// Stop presenting requests once either queue is almost full
	assign input_wait_o = wb_q.almost_full || ld_q.almost_full;

	// A new miss must always find a free slot in the table
	a_no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
		alloc |-> !(&pend_valid));

	// Once the wait has been up longer than the pipeline depth, nothing may arrive
	a_no_enq_after_wait: assert property (@(posedge clk) disable iff (reset)
		input_wait_o [*WAIT_CYCLES] |-> !(wb_q.enqueue || ld_q.enqueue));

endmodule

//--- source/l2_request_fifo.sv
module l2_request_fifo #(
	parameter int ENTRY_WIDTH = 1,
	parameter int DEPTH = 8,
	parameter int ALMOST_FULL_MARGIN = 4
) (
	input logic clk,
	input logic reset,
	l2_queue_if.fifo q
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [ENTRY_WIDTH - 1:0] mem [DEPTH];
	logic [PTR_W - 1:0] wr_ptr;
	logic [PTR_W - 1:0] rd_ptr;
	logic [CNT_W - 1:0] count;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap by hand so any depth works
			if (q.enqueue)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (q.dequeue)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (q.enqueue && !q.dequeue)
				count <= count + 1'b1;
			else if (!q.enqueue && q.dequeue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (q.enqueue)
			mem[wr_ptr] <= q.enq_entry;
	end

	assign q.head = mem[rd_ptr];
	assign q.empty = count == '0;

	// Leave room for the requests still inside the pipeline
	assign q.almost_full = count >= CNT_W'(DEPTH - ALMOST_FULL_MARGIN);

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		q.enqueue && !q.dequeue |-> count < CNT_W'(DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		q.dequeue |-> !q.empty);

endmodule

//--- source/l2_bus_engine.sv
module l2_bus_engine #(
	parameter int BEAT_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	l2_queue_if.consumer wb_q,
	l2_queue_if.consumer ld_q,
	output logic ret_valid_o,
	output logic ret_duplicate_o,
	output l2_bus_pkg::req_id_t ret_id_o,
	output l2_bus_pkg::l2_op_e ret_op_o,
	output l2_bus_pkg::line_addr_t ret_addr_o,
	output l2_bus_pkg::byte_mask_t ret_mask_o,
	output l2_bus_pkg::line_t ret_line_o,
	output logic [31:0] awaddr_o,
	output logic [7:0] awlen_o,
	output logic awvalid_o,
	input logic awready_i,
	output logic [BEAT_WIDTH - 1:0] wdata_o,
	output logic wlast_o,
	output logic wvalid_o,
	input logic wready_i,
	input logic bvalid_i,
	output logic bready_o,
	output logic [31:0] araddr_o,
	output logic [7:0] arlen_o,
	output logic arvalid_o,
	input logic arready_i,
	input logic [BEAT_WIDTH - 1:0] rdata_i,
	input logic rvalid_i,
	output logic rready_o
);
	import l2_bus_pkg::*;

	localparam int BEATS = LINE_WIDTH / BEAT_WIDTH;
	localparam int BEAT_CNT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	bus_state_e state;
	bus_state_e next_state;
	logic [BEAT_CNT_W - 1:0] beat_cnt;
	logic last_beat;
	logic wait_bresp;
	logic skip_read;
	logic [BEATS - 1:0][BEAT_WIDTH - 1:0] line_buf;
	line_addr_t wb_addr;
	line_t wb_line;
	logic [OP_BITS - 1:0] ld_op_bits;

	// Split the queue heads into their fields
	assign {wb_addr, wb_line} = wb_q.head;
	assign {ret_duplicate_o, ret_id_o, ld_op_bits, ret_addr_o, ret_mask_o} = ld_q.head;
	assign ret_op_o = l2_op_e'(ld_op_bits);
	assign ret_line_o = line_buf;

	// Byte addresses of whole lines and bursts of one full line
	assign awaddr_o = 32'(wb_addr) << OFFSET_BITS;
	assign araddr_o = 32'(ret_addr_o) << OFFSET_BITS;
	assign awlen_o = 8'(BEATS - 1);
	assign arlen_o = 8'(BEATS - 1);
	assign bready_o = 1'b1;

	// Beat k of the writeback takes line bits k * BEAT_WIDTH upward
	assign wdata_o = wb_line[beat_cnt * BEAT_WIDTH +: BEAT_WIDTH];
	assign last_beat = beat_cnt == BEAT_CNT_W'(BEATS - 1);

	// A duplicate is picked up from the earlier miss, and a full store overwrites the whole line
	assign skip_read = ret_duplicate_o || (ret_op_o == OP_STORE && ret_mask_o == '1);

	always_comb
	begin
		next_state = state;
		awvalid_o = 1'b0;
		wvalid_o = 1'b0;
		wlast_o = 1'b0;
		arvalid_o = 1'b0;
		rready_o = 1'b0;
		ret_valid_o = 1'b0;
		wb_q.dequeue = 1'b0;
		ld_q.dequeue = 1'b0;
		case (state)
			IDLE:
			begin
				// Writebacks go first so a later load never sees stale memory
				if (!wb_q.empty)
				begin
					if (!wait_bresp)
						next_state = WRITE_ADDR;
				end
				else if (!ld_q.empty)
					next_state = skip_read ? READ_DONE : READ_ADDR;
			end
			WRITE_ADDR:
			begin
				awvalid_o = 1'b1;
				if (awready_i)
					next_state = WRITE_DATA;
			end
			WRITE_DATA:
			begin
				wvalid_o = 1'b1;
				wlast_o = last_beat;
				if (wready_i && last_beat)
				begin
					wb_q.dequeue = 1'b1;
					next_state = IDLE;
				end
			end
			READ_ADDR:
			begin
				arvalid_o = 1'b1;
				if (arready_i)
					next_state = READ_DATA;
			end
			READ_DATA:
			begin
				rready_o = 1'b1;
				if (rvalid_i && last_beat)
					next_state = READ_DONE;
			end
			READ_DONE:
			begin
				// Hand the request back to the arbiter with the fetched line
				ret_valid_o = 1'b1;
				ld_q.dequeue = 1'b1;
				next_state = IDLE;
			end
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			beat_cnt <= '0;
			wait_bresp <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == WRITE_ADDR || state == READ_ADDR)
				beat_cnt <= '0;
			else if ((state == WRITE_DATA && wready_i) || (state == READ_DATA && rvalid_i))
				beat_cnt <= beat_cnt + 1'b1;

			// The response for a burst can only follow its last data beat
			if (state == WRITE_DATA && wready_i && last_beat)
				wait_bresp <= 1'b1;
			else if (bvalid_i)
				wait_bresp <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == READ_DATA && rvalid_i)
			line_buf[beat_cnt] <= rdata_i;
	end

	// The memory only answers a write burst whose last beat has gone out
	a_bresp_outstanding: assert property (@(posedge clk) disable iff (reset)
		bvalid_i |-> wait_bresp);

endmodule

//--- source/l2_bus_interface.sv
module l2_bus_interface #(
	parameter int BEAT_WIDTH = 32,
	parameter int PENDING_ENTRIES = 8
) (
	input logic clk,
	input logic reset,
	input logic rd_valid_i,
	input l2_bus_pkg::l2_op_e rd_op_i,
	input l2_bus_pkg::req_id_t rd_id_i,
	input l2_bus_pkg::line_addr_t rd_addr_i,
	input l2_bus_pkg::byte_mask_t rd_mask_i,
	input logic rd_is_fill_i,
	input logic rd_hit_i,
	input logic rd_dirty_i,
	input l2_bus_pkg::l2_tag_t rd_old_tag_i,
	input l2_bus_pkg::line_t rd_line_i,
	output logic input_wait_o,
	output logic ret_valid_o,
	output logic ret_duplicate_o,
	output l2_bus_pkg::req_id_t ret_id_o,
	output l2_bus_pkg::l2_op_e ret_op_o,
	output l2_bus_pkg::line_addr_t ret_addr_o,
	output l2_bus_pkg::byte_mask_t ret_mask_o,
	output l2_bus_pkg::line_t ret_line_o,
	output logic [31:0] awaddr_o,
	output logic [7:0] awlen_o,
	output logic awvalid_o,
	input logic awready_i,
	output logic [BEAT_WIDTH - 1:0] wdata_o,
	output logic wlast_o,
	output logic wvalid_o,
	input logic wready_i,
	input logic bvalid_i,
	output logic bready_o,
	output logic [31:0] araddr_o,
	output logic [7:0] arlen_o,
	output logic arvalid_o,
	input logic arready_i,
	input logic [BEAT_WIDTH - 1:0] rdata_i,
	input logic rvalid_i,
	output logic rready_o
);
	import l2_bus_pkg::*;

	// One queue of victims to write back and one of misses to read
	l2_queue_if #(.ENTRY_WIDTH(WB_ENTRY_WIDTH)) wb_q ();
	l2_queue_if #(.ENTRY_WIDTH(LD_ENTRY_WIDTH)) ld_q ();

	l2_miss_classifier #(
		.PENDING_ENTRIES(PENDING_ENTRIES)
	) classifier (
		.clk(clk),
		.reset(reset),
		.rd_valid_i(rd_valid_i),
		.rd_op_i(rd_op_i),
		.rd_id_i(rd_id_i),
		.rd_addr_i(rd_addr_i),
		.rd_mask_i(rd_mask_i),
		.rd_is_fill_i(rd_is_fill_i),
		.rd_hit_i(rd_hit_i),
		.rd_dirty_i(rd_dirty_i),
		.rd_old_tag_i(rd_old_tag_i),
		.rd_line_i(rd_line_i),
		.wb_q(wb_q.producer),
		.ld_q(ld_q.producer),
		.input_wait_o(input_wait_o)
	);

	l2_request_fifo #(
		.ENTRY_WIDTH(WB_ENTRY_WIDTH),
		.DEPTH(QUEUE_DEPTH),
		.ALMOST_FULL_MARGIN(REQ_LATENCY)
	) writeback_queue (
		.clk(clk),
		.reset(reset),
		.q(wb_q.fifo)
	);

	l2_request_fifo #(
		.ENTRY_WIDTH(LD_ENTRY_WIDTH),
		.DEPTH(QUEUE_DEPTH),
		.ALMOST_FULL_MARGIN(REQ_LATENCY)
	) load_queue (
		.clk(clk),
		.reset(reset),
		.q(ld_q.fifo)
	);

	l2_bus_engine #(
		.BEAT_WIDTH(BEAT_WIDTH)
	) engine (
		.clk(clk),
		.reset(reset),
		.wb_q(wb_q.consumer),
		.ld_q(ld_q.consumer),
		.ret_valid_o(ret_valid_o),
		.ret_duplicate_o(ret_duplicate_o),
		.ret_id_o(ret_id_o),
		.ret_op_o(ret_op_o),
		.ret_addr_o(ret_addr_o),
		.ret_mask_o(ret_mask_o),
		.ret_line_o(ret_line_o),
		.awaddr_o(awaddr_o),
		.awlen_o(awlen_o),
		.awvalid_o(awvalid_o),
		.awready_i(awready_i),
		.wdata_o(wdata_o),
		.wlast_o(wlast_o),
		.wvalid_o(wvalid_o),
		.wready_i(wready_i),
		.bvalid_i(bvalid_i),
		.bready_o(bready_o),
		.araddr_o(araddr_o),
		.arlen_o(arlen_o),
		.arvalid_o(arvalid_o),
		.arready_i(arready_i),
		.rdata_i(rdata_i),
		.rvalid_i(rvalid_i),
		.rready_o(rready_o)
	);

endmodule

//--- sim/axi_mem_model.sv
module axi_mem_model #(
	parameter int BEAT_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic [3:0] stall_i,
	input logic [31:0] awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input logic [BEAT_WIDTH - 1:0] wdata_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic bvalid_o,
	input logic [31:0] araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic [BEAT_WIDTH - 1:0] rdata_o,
	output logic rvalid_o,
	input logic rready_i,
	output logic wr_done_o,
	output l2_bus_pkg::line_addr_t wr_addr_o,
	output l2_bus_pkg::line_t wr_line_o,
	output int read_bursts_o,
	output int write_bursts_o
);
	import l2_bus_pkg::*;

	localparam int BEATS = LINE_WIDTH / BEAT_WIDTH;

	// Lines written so far, anything never written reads as the fill pattern
	line_t mem [line_addr_t];
	logic wr_active;
	logic rd_active;
	line_addr_t wr_addr;
	int wr_beat;
	int rd_beat;
	logic [BEATS - 1:0][BEAT_WIDTH - 1:0] wr_buf;
	logic [BEATS - 1:0][BEAT_WIDTH - 1:0] rd_buf;

	function automatic line_t line_at(input line_addr_t a);
		line_t l;
		if (mem.exists(a))
			return mem[a];
		// Every 32-bit word carries the whole line address and its own index
		for (int k = 0; k < LINE_WIDTH / 32; k++)
			l[k * 32 +: 32] = {a, 6'(k)} ^ 32'h5bd1_e995;
		return l;
	endfunction

	// One stall bit per channel holds that channel off for a cycle
	assign awready_o = !wr_active && !stall_i[0];
	assign wready_o = wr_active && !stall_i[1];
	assign arready_o = !rd_active && !stall_i[2];
	assign rvalid_o = rd_active && !stall_i[3];
	assign rdata_o = rd_buf[rd_beat];

	always @(posedge clk or posedge reset)
	begin : respond
		logic [BEATS - 1:0][BEAT_WIDTH - 1:0] next_line;
		if (reset)
		begin
			wr_active <= 1'b0;
			rd_active <= 1'b0;
			wr_beat <= 0;
			rd_beat <= 0;
			bvalid_o <= 1'b0;
			wr_done_o <= 1'b0;
			read_bursts_o <= 0;
			write_bursts_o <= 0;
		end
		else
		begin
			bvalid_o <= 1'b0;
			wr_done_o <= 1'b0;
			if (awvalid_i && awready_o)
			begin
				wr_active <= 1'b1;
				wr_addr <= line_addr_t'(awaddr_i >> OFFSET_BITS);
				wr_beat <= 0;
			end
			if (wvalid_i && wready_o)
			begin
				next_line = wr_buf;
				next_line[wr_beat] = wdata_i;
				wr_buf <= next_line;
				wr_beat <= (wr_beat == BEATS - 1) ? 0 : wr_beat + 1;
				// The last beat commits the line and answers on the response channel
				if (wr_beat == BEATS - 1)
				begin
					mem[wr_addr] = next_line;
					wr_active <= 1'b0;
					bvalid_o <= 1'b1;
					wr_done_o <= 1'b1;
					wr_addr_o <= wr_addr;
					wr_line_o <= next_line;
					write_bursts_o <= write_bursts_o + 1;
				end
			end
			if (arvalid_i && arready_o)
			begin
				rd_active <= 1'b1;
				rd_buf <= line_at(line_addr_t'(araddr_i >> OFFSET_BITS));
				rd_beat <= 0;
			end
			if (rvalid_o && rready_i)
			begin
				rd_beat <= (rd_beat == BEATS - 1) ? 0 : rd_beat + 1;
				if (rd_beat == BEATS - 1)
				begin
					rd_active <= 1'b0;
					read_bursts_o <= read_bursts_o + 1;
				end
			end
		end
	end

endmodule

//--- sim/l2_bus_tb.sv
module l2_bus_tb;
	import l2_bus_pkg::*;

	localparam int BEAT_WIDTH = 32;
	localparam int BEATS = LINE_WIDTH / BEAT_WIDTH;
	localparam int RANDOM_REQUESTS = 200;
	localparam int TOTAL_REQUESTS = RANDOM_REQUESTS + 40;
	// Longest burst with its address phase and ready stalls plus a wide margin
	localparam int CYCLES_PER_REQUEST = 8 * (BEATS + 4);
	localparam int CLK_PERIOD = 20;
	localparam l2_op_e MISS_OPS [4] = '{OP_LOAD, OP_STORE, OP_LOAD_SYNC, OP_STORE_SYNC};

	typedef struct packed {
		logic duplicate;
		logic check_line;
		req_id_t id;
		l2_op_e op;
		line_addr_t addr;
		byte_mask_t mask;
		line_t line;
	} ret_exp_t;

	typedef struct packed {
		line_addr_t addr;
		line_t data;
	} wb_exp_t;

	logic clk;
	logic reset;
	logic rd_valid_i;
	l2_op_e rd_op_i;
	req_id_t rd_id_i;
	line_addr_t rd_addr_i;
	byte_mask_t rd_mask_i;
	logic rd_is_fill_i;
	logic rd_hit_i;
	logic rd_dirty_i;
	l2_tag_t rd_old_tag_i;
	line_t rd_line_i;
	logic input_wait_o;
	logic ret_valid_o;
	logic ret_duplicate_o;
	req_id_t ret_id_o;
	l2_op_e ret_op_o;
	line_addr_t ret_addr_o;
	byte_mask_t ret_mask_o;
	line_t ret_line_o;
	logic [31:0] awaddr_o;
	logic [7:0] awlen_o;
	logic awvalid_o;
	logic awready_i;
	logic [BEAT_WIDTH - 1:0] wdata_o;
	logic wlast_o;
	logic wvalid_o;
	logic wready_i;
	logic bvalid_i;
	logic bready_o;
	logic [31:0] araddr_o;
	logic [7:0] arlen_o;
	logic arvalid_o;
	logic arready_i;
	logic [BEAT_WIDTH - 1:0] rdata_i;
	logic rvalid_i;
	logic rready_o;

	logic [3:0] stall;
	logic wr_done;
	line_addr_t wr_addr;
	line_t wr_line;
	int read_bursts;
	int write_bursts;

	// Scoreboards, shadow memory and the model of the outstanding miss table
	ret_exp_t returns_due [$];
	wb_exp_t writes_due [$];
	line_t shadow [line_addr_t];
	bit pending [line_addr_t];
	logic [31:0] lfsr;
	string test_name;
	int errors;
	int checks;
	int tests;
	int errors_at_start;
	int reads_at_start;
	int writes_at_start;
	int exp_reads;
	int exp_writes;

	// Entries each queue should hold, and write beats sent in the current burst
	int ld_queued;
	int wb_queued;
	int beats_sent;

	l2_bus_interface #(
		.BEAT_WIDTH(BEAT_WIDTH),
		.PENDING_ENTRIES(8)
	) UUT (.*);

	axi_mem_model #(
		.BEAT_WIDTH(BEAT_WIDTH)
	) memory (
		.clk(clk),
		.reset(reset),
		.stall_i(stall),
		.awaddr_i(awaddr_o),
		.awvalid_i(awvalid_o),
		.awready_o(awready_i),
		.wdata_i(wdata_o),
		.wvalid_i(wvalid_o),
		.wready_o(wready_i),
		.bvalid_o(bvalid_i),
		.araddr_i(araddr_o),
		.arvalid_i(arvalid_o),
		.arready_o(arready_i),
		.rdata_o(rdata_i),
		.rvalid_o(rvalid_i),
		.rready_i(rready_o),
		.wr_done_o(wr_done),
		.wr_addr_o(wr_addr),
		.wr_line_o(wr_line),
		.read_bursts_o(read_bursts),
		.write_bursts_o(write_bursts)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step for every bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] b;
		b = '0;
		for (int i = 0; i < n; i++)
		begin
			b = {b[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return b;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int k = 0; k < LINE_WIDTH / 32; k++)
			l[k * 32 +: 32] = take_bits(32);
		return l;
	endfunction

	// Memory content before any write is built from the whole line address
	function automatic line_t pattern_line(input line_addr_t a);
		line_t l;
		for (int k = 0; k < LINE_WIDTH / 32; k++)
			l[k * 32 +: 32] = {a, 6'(k)} ^ 32'h5bd1_e995;
		return l;
	endfunction

	function automatic line_t expected_line(input line_addr_t a);
		if (!shadow.exists(a))
			shadow[a] = pattern_line(a);
		return shadow[a];
	endfunction

	// Every input change happens here on the falling edge
	task automatic tick();
		logic wait_due;
		@(negedge clk);
		// Either queue at its almost-full level holds the pipeline back
		wait_due = ld_queued >= QUEUE_DEPTH - REQ_LATENCY
			|| wb_queued >= QUEUE_DEPTH - REQ_LATENCY;
		check_value("input_wait", wait_due, input_wait_o);
		// Each channel stalls about one cycle in four
		for (int c = 0; c < 4; c++)
			stall[c] = take_bits(2) == 32'd3;
	endtask

	task automatic check_value(input string what, input logic [LINE_WIDTH - 1:0] expected,
		input logic [LINE_WIDTH - 1:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	// Drive one request and predict what the bus side must do with it
	task automatic present(input l2_op_e op, input req_id_t id, input line_addr_t addr,
		input byte_mask_t mask, input logic is_fill, input logic hit, input logic dirty,
		input l2_tag_t old_tag, input line_t line);
		ret_exp_t want;
		wb_exp_t wb;
		while (input_wait_o)
			tick();
		rd_valid_i = 1'b1;
		rd_op_i = op;
		rd_id_i = id;
		rd_addr_i = addr;
		rd_mask_i = mask;
		rd_is_fill_i = is_fill;
		rd_hit_i = hit;
		rd_dirty_i = dirty;
		rd_old_tag_i = old_tag;
		rd_line_i = line;
		// The victim goes back to memory under its old tag in the same set
		if (dirty && (is_fill || op == OP_FLUSH))
		begin
			wb.addr = {old_tag, addr[SET_BITS - 1:0]};
			wb.data = line;
			shadow[wb.addr] = line;
			writes_due.push_back(wb);
			exp_writes++;
			wb_queued++;
		end
		if (!hit && !is_fill && op inside {OP_LOAD, OP_STORE, OP_LOAD_SYNC, OP_STORE_SYNC})
		begin
			want.duplicate = pending.exists(addr) != 0;
			if (!want.duplicate)
				pending[addr] = 1'b1;
			want.id = id;
			want.op = op;
			want.addr = addr;
			want.mask = mask;
			// Duplicates and whole-line stores come back without a read
			want.check_line = !want.duplicate && !(op == OP_STORE && mask == '1);
			want.line = want.check_line ? expected_line(addr) : '0;
			if (want.check_line)
				exp_reads++;
			returns_due.push_back(want);
			ld_queued++;
		end
		if (is_fill)
			pending.delete(addr);
		tick();
		rd_valid_i = 1'b0;
	endtask

	task automatic miss_request(input l2_op_e op, input req_id_t id, input line_addr_t addr,
		input byte_mask_t mask);
		present(op, id, addr, mask, 1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic fill_request(input line_addr_t addr, input logic dirty,
		input l2_tag_t old_tag, input line_t line);
		present(OP_LOAD, 4'd0, addr, '0, 1'b1, 1'b0, dirty, old_tag, line);
	endtask

	// Clean fills for every open miss leave the table empty for the next test
	task automatic release_misses();
		line_addr_t keys [$];
		foreach (pending[a])
			keys.push_back(a);
		foreach (keys[i])
			fill_request(keys[i], 1'b0, '0, '0);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		reads_at_start = read_bursts;
		writes_at_start = write_bursts;
		exp_reads = 0;
		exp_writes = 0;
	endtask

	task automatic end_test();
		release_misses();
		while (returns_due.size() != 0 || writes_due.size() != 0)
			tick();
		// A quiet stretch shows up any burst or return that should not be there
		repeat (4 * BEATS)
			tick();
		check_value("read bursts", exp_reads, read_bursts - reads_at_start);
		check_value("write bursts", exp_writes, write_bursts - writes_at_start);
		tests++;
		if (errors == errors_at_start)
			$display("%s: passed", test_name);
		else
			$display("%s: failed with %0d errors", test_name, errors - errors_at_start);
	endtask

	task automatic loads_in_order();
		begin_test("loads_in_order");
		miss_request(OP_LOAD, 4'd1, {1'b0, 19'h01234, 6'd0}, 16'h00ff);
		miss_request(OP_LOAD_SYNC, 4'd2, {1'b0, 19'h01234, 6'd1}, 16'hffff);
		miss_request(OP_STORE, 4'd3, {1'b0, 19'h01234, 6'd2}, 16'h0f0f);
		miss_request(OP_STORE_SYNC, 4'd4, {1'b0, 19'h01234, 6'd3}, 16'hffff);
		end_test();
	endtask

	task automatic writeback_before_load();
		line_t data;
		begin_test("writeback_before_load");
		data = random_line();
		fill_request({1'b0, 19'h02000, 6'd5}, 1'b1, 20'h8777a, data);
		// Read straight back what the fill just evicted
		miss_request(OP_LOAD, 4'd5, {20'h8777a, 6'd5}, '1);
		data = random_line();
		present(OP_FLUSH, 4'd6, {1'b0, 19'h02000, 6'd9}, '0, 1'b0, 1'b1, 1'b1, 20'h8777b, data);
		miss_request(OP_LOAD_SYNC, 4'd7, {20'h8777b, 6'd9}, '1);
		end_test();
	endtask

	task automatic duplicate_misses();
		line_addr_t a;
		a = {1'b0, 19'h03000, 6'd7};
		begin_test("duplicate_misses");
		miss_request(OP_LOAD, 4'd1, a, 16'h0001);
		miss_request(OP_LOAD_SYNC, 4'd2, a, 16'h0002);
		miss_request(OP_STORE, 4'd3, a, 16'h0003);
		// Once the fill is seen the address misses for real again
		fill_request(a, 1'b0, '0, '0);
		miss_request(OP_LOAD, 4'd4, a, 16'h0004);
		end_test();
	endtask

	task automatic full_mask_stores();
		begin_test("full_mask_stores");
		miss_request(OP_STORE, 4'd1, {1'b0, 19'h04000, 6'd1}, '1);
		miss_request(OP_STORE, 4'd2, {1'b0, 19'h04000, 6'd2}, 16'h7fff);
		miss_request(OP_STORE_SYNC, 4'd3, {1'b0, 19'h04000, 6'd3}, '1);
		end_test();
	endtask

	task automatic silent_requests();
		line_t data;
		data = random_line();
		begin_test("silent_requests");
		present(OP_LOAD, 4'd1, {1'b0, 19'h05000, 6'd0}, '1, 1'b0, 1'b1, 1'b1, 20'h81111, data);
		fill_request({1'b0, 19'h05000, 6'd1}, 1'b0, 20'h81112, data);
		present(OP_INVALIDATE, 4'd3, {1'b0, 19'h05000, 6'd2}, '0, 1'b0, 1'b0, 1'b1, 20'h81113,
			data);
		present(OP_STORE, 4'd4, {1'b0, 19'h05000, 6'd3}, '1, 1'b0, 1'b1, 1'b0, 20'h81114, data);
		end_test();
	endtask

	// Loads stay below bit 25 and victims above it, so no load races a writeback
	task automatic random_stream();
		logic [2:0] kind;
		l2_op_e op;
		req_id_t id;
		line_addr_t addr;
		l2_tag_t old_tag;
		logic dirty;
		byte_mask_t mask;
		line_t data;
		begin_test("random_stream");
		for (int n = 0; n < RANDOM_REQUESTS; n++)
		begin
			kind = 3'(take_bits(3));
			op = MISS_OPS[take_bits(2)];
			id = 4'(take_bits(4));
			addr = {1'b0, 19'h00a5c, 6'(take_bits(3))};
			old_tag = {1'b1, 19'(take_bits(19))};
			dirty = take_bits(1) == 32'd1;
			mask = (take_bits(1) == 32'd1) ? '1 : 16'(take_bits(16));
			data = random_line();
			case (kind)
				3'd0, 3'd1, 3'd2, 3'd3:
					miss_request(op, id, addr, mask);
				3'd4, 3'd5:
					fill_request(addr, dirty, old_tag, data);
				3'd6:
					present(OP_FLUSH, id, addr, mask, 1'b0, 1'b1, dirty, old_tag, data);
				default:
					present(dirty ? OP_INVALIDATE : OP_STORE, id, addr, mask, 1'b0, 1'b1, dirty,
						old_tag, data);
			endcase
			if (take_bits(2) == 32'd0)
				tick();
		end
		end_test();
	endtask

	// Returns must come out in request order with the predicted fields
	always @(negedge clk)
	begin : compare_returns
		ret_exp_t want;
		if (!reset && ret_valid_o)
		begin
			if (returns_due.size() == 0)
			begin
				errors++;
				$display("Error in %s: a return came with no request outstanding", test_name);
			end
			else
			begin
				want = returns_due.pop_front();
				check_value("ret_duplicate", want.duplicate, ret_duplicate_o);
				check_value("ret_id", want.id, ret_id_o);
				check_value("ret_op", want.op, ret_op_o);
				check_value("ret_addr", want.addr, ret_addr_o);
				check_value("ret_mask", want.mask, ret_mask_o);
				if (want.check_line)
					check_value("ret_line", want.line, ret_line_o);
			end
		end
	end

	always @(negedge clk)
	begin : compare_writebacks
		wb_exp_t want;
		if (!reset && wr_done)
		begin
			if (writes_due.size() == 0)
			begin
				errors++;
				$display("Error in %s: a write burst came with no writeback outstanding",
					test_name);
			end
			else
			begin
				want = writes_due.pop_front();
				check_value("writeback address", want.addr, wr_addr);
				check_value("writeback line", want.data, wr_line);
			end
		end
	end

	// Follow the pops of both queues and check the burst fields that the memory model ignores
	always @(posedge clk)
	begin : watch_bus
		if (!reset)
		begin
			check_value("bready", 1'b1, bready_o);
			if (awvalid_o)
				check_value("awlen", BEATS - 1, awlen_o);
			if (arvalid_o)
				check_value("arlen", BEATS - 1, arlen_o);
			// The return cycle pops the load queue on this edge
			if (ret_valid_o)
				ld_queued--;
			if (wvalid_o)
			begin
				check_value("wlast", beats_sent == BEATS - 1, wlast_o);
				if (wready_i)
				begin
					// The last accepted beat pops the writeback queue
					if (beats_sent == BEATS - 1)
					begin
						beats_sent = 0;
						wb_queued--;
					end
					else
						beats_sent++;
				end
			end
		end
	end

	initial
	begin
		#(TOTAL_REQUESTS * CYCLES_PER_REQUEST * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles",
			TOTAL_REQUESTS * CYCLES_PER_REQUEST);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		lfsr = 32'ha3c1_bcd6;
		errors = 0;
		checks = 0;
		tests = 0;
		ld_queued = 0;
		wb_queued = 0;
		beats_sent = 0;
		test_name = "reset";
		reset = 1'b1;
		stall = '0;
		rd_valid_i = 1'b0;
		rd_op_i = OP_LOAD;
		rd_id_i = '0;
		rd_addr_i = '0;
		rd_mask_i = '0;
		rd_is_fill_i = 1'b0;
		rd_hit_i = 1'b0;
		rd_dirty_i = 1'b0;
		rd_old_tag_i = '0;
		rd_line_i = '0;
		repeat (4)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		loads_in_order();
		writeback_before_load();
		duplicate_misses();
		full_mask_stores();
		silent_requests();
		random_stream();

		$display("Ran %0d tests with %0d checks and %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- sim.f
source/l2_bus_pkg.sv
source/l2_queue_if.sv
source/l2_miss_classifier.sv
source/l2_request_fifo.sv
source/l2_bus_engine.sv
source/l2_bus_interface.sv
sim/axi_mem_model.sv
sim/l2_bus_tb.sv

//--- Bender.yml
package:
  name: l2_bus_interface

sources:
  - source/l2_bus_pkg.sv
  - source/l2_queue_if.sv
  - source/l2_miss_classifier.sv
  - source/l2_request_fifo.sv
  - source/l2_bus_engine.sv
  - source/l2_bus_interface.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/l2_bus_tb.sv
